// ==== project.f ====
+incdir+.
vector_types_pkg.sv
vector_cmd_pkg.sv
vector_regfile.sv
vector_operand_sel.sv
vector_alu.sv
vector_ctrl.sv
vector_unit_top.sv
tb_vector_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the vector unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_vector_unit -o sim_vector_unit -f project.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/sim_vector_unit > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi

echo "Pass message not found in sim.log"
exit 1

// ==== tb_vector_unit.sv ====
`timescale 1ns/1ps

`include "vector_params.svh"

module tb_vector_unit
    import vector_types_pkg::*;
    import vector_cmd_pkg::*;
();

    localparam int VLEN  = `VEC_VLEN;
    localparam int NREGS = `VEC_NREGS;

    typedef logic [VLEN-1:0] vreg_t;

    logic        clk;
    logic        reset;
    logic        req;
    vec_cmd_t    cmd;
    logic        ack;
    vec_rsp_t    rsp;

    // Reference model state
    vreg_t       m_regs [NREGS];
    vtype_t      m_vtype;
    logic [31:0] m_vl;

    int unsigned n_cmds = 0;

    vector_unit_top DUT (
        .clk   (clk),
        .reset (reset),
        .req_i (req),
        .cmd_i (cmd),
        .ack_o (ack),
        .rsp_o (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Handshake checks
    //////////////////////////////////////////////////////////////////////

    // No ack without a request
    assert property (@(posedge clk) disable iff (reset) (!req && !ack) |=> !ack)
        else abort_run($sformatf("ERR %0t: ack rose with no request", $time));

    // Ack held until the host lets go
    assert property (@(posedge clk) disable iff (reset) (req && ack) |=> ack)
        else abort_run($sformatf("ERR %0t: ack fell while req was high", $time));

    // Limit of 200 cycles per issued command
    initial begin
        longint cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 200 * (longint'(n_cmds) + 1) + 16) begin
                abort_run("Timeout: the run went past its cycle limit");
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Command driver
    //////////////////////////////////////////////////////////////////////

    task automatic wait_ack(input logic level);
        int waited;
        waited = 0;
        while (ack !== level) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 200) begin
                abort_run("Timeout: the DUT did not move ack as the handshake requires");
            end
        end
    endtask

    // Starts and ends 2 ns after a rising edge
    task automatic send_cmd(input vec_cmd_t c, output vec_rsp_t r);
        cmd = c;
        req = 1'b1;
        n_cmds++;
        wait_ack(1'b1);
        r = rsp;
        // Response must hold while req stays high
        repeat ($urandom_range(0, 2)) begin
            @(posedge clk);
            #2;
            assert (rsp == r)
                else abort_run($sformatf("ERR %0t: response changed while ack was high", $time));
        end
        req = 1'b0;
        wait_ack(1'b0);
        // Idle gap with req low
        repeat ($urandom_range(1, 2)) begin
            @(posedge clk);
            #2;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic int sew_bits(input vew_e s);
        return 8 << s;
    endfunction

    function automatic logic [31:0] elem_mask(input int sb);
        if (sb >= 32) begin
            return 32'hffff_ffff;
        end else begin
            return (32'd1 << sb) - 32'd1;
        end
    endfunction

    function automatic logic [31:0] elem_rd(input vreg_t v, input int e, input int sb);
        return 32'(v >> (e * sb)) & elem_mask(sb);
    endfunction

    task automatic elem_wr(input logic [4:0] r, input int e, input int sb, input logic [31:0] val);
        vreg_t msk;
        msk = vreg_t'(elem_mask(sb)) << (e * sb);
        m_regs[r] = (m_regs[r] & ~msk) | ((vreg_t'(val) << (e * sb)) & msk);
    endtask

    function automatic logic [31:0] vlmax_of(input vtype_t vt);
        return 32'((VLEN / sew_bits(vt.vsew)) << vt.vlmul);
    endfunction

    task automatic model_vset(input vec_cmd_t c);
        vtype_t      vt;
        logic [31:0] vlmax;
        logic [31:0] avl;
        if (c.op == VSETVL) begin
            // vtype CSR layout
            vt.vill  = c.scalar2[31];
            vt.vma   = c.scalar2[7];
            vt.vta   = c.scalar2[6];
            vt.vsew  = vew_e'(c.scalar2[5:3]);
            vt.vlmul = vlmul_e'(c.scalar2[2:0]);
        end else begin
            vt = c.vtype_imm;
        end
        if (vt.vill || vt.vsew > EW32) begin
            m_vtype      = '0;
            m_vtype.vill = 1'b1;
            m_vl         = '0;
        end else begin
            vlmax = vlmax_of(vt);
            if (c.op == VSETIVLI) begin
                avl = 32'(c.imm5);
            end else if (c.vd != 5'd0 && c.vs1 == 5'd0) begin
                avl = vlmax;
            end else begin
                avl = c.scalar1;
            end
            m_vtype = vt;
            // rd and rs1 both zero keep vl
            if (c.op == VSETIVLI || c.vd != 5'd0 || c.vs1 != 5'd0) begin
                m_vl = (avl < vlmax) ? avl : vlmax;
            end
        end
    endtask

    // Every element comes from the state before the command
    task automatic model_op(input vec_cmd_t c);
        vreg_t       old [NREGS];
        int          sb;
        int          epr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  dst;
        old = m_regs;
        sb  = sew_bits(m_vtype.vsew);
        epr = VLEN / sb;
        for (int k = 0; k < (1 << m_vtype.vlmul); k++) begin
            for (int e = 0; e < epr; e++) begin
                if (!m_vtype.vill && 32'(k * epr + e) < m_vl) begin
                    a = elem_rd(old[c.vs2 + 5'(k)], e, sb);
                    case (c.cat)
                        OPIVV:   b = elem_rd(old[c.vs1 + 5'(k)], e, sb);
                        OPIVX:   b = c.scalar1 & elem_mask(sb);
                        default: b = 32'($signed(c.imm5)) & elem_mask(sb);
                    endcase
                    case (c.op)
                        VAND:    res = a & b;
                        VOR:     res = a | b;
                        VXOR:    res = a ^ b;
                        VADD:    res = a + b;
                        default: res = a - b;
                    endcase
                    dst = c.vd + 5'(k);
                    if (dst != 5'd0) begin
                        elem_wr(dst, e, sb, res & elem_mask(sb));
                    end
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Command helpers
    //////////////////////////////////////////////////////////////////////

    task automatic do_vset(input vec_cmd_t c);
        vec_rsp_t r;
        send_cmd(c, r);
        model_vset(c);
        assert (r.wr_en === 1'b1 && r.data === m_vl)
            else abort_run($sformatf("ERR %0t: vset returned vl %0d, expected %0d",
                                     $time, r.data, m_vl));
    endtask

    task automatic set_cfg(input vew_e sew, input vlmul_e lmul, input logic [31:0] avl);
        vec_cmd_t c;
        c                 = '0;
        c.op              = VSETVLI;
        c.vd              = 5'd1;
        c.vs1             = 5'd1;
        c.scalar1         = avl;
        c.vtype_imm.vsew  = sew;
        c.vtype_imm.vlmul = lmul;
        do_vset(c);
    endtask

    task automatic run_op(input vec_cmd_t c);
        vec_rsp_t r;
        send_cmd(c, r);
        model_op(c);
        assert (r.wr_en === 1'b0)
            else abort_run($sformatf("ERR %0t: element-wise op set wr_en", $time));
    endtask

    // Load through vadd.vx with v0 as the vector source
    task automatic load_group(input logic [4:0] vd, input logic [31:0] value);
        vec_cmd_t c;
        c         = '0;
        c.op      = VADD;
        c.cat     = OPIVX;
        c.vd      = vd;
        c.scalar1 = value;
        run_op(c);
    endtask

    task automatic check_elem(input logic [4:0] r, input int e);
        vec_cmd_t    c;
        vec_rsp_t    rs;
        logic [31:0] exp;
        c         = '0;
        c.op      = VEXT;
        c.vs2     = r;
        c.scalar1 = 32'(e);
        send_cmd(c, rs);
        exp = elem_rd(m_regs[r], e, sew_bits(m_vtype.vsew));
        assert (rs.wr_en === 1'b1 && rs.data === exp)
            else abort_run($sformatf("ERR %0t: v%0d[%0d] read %h, expected %h",
                                     $time, r, e, rs.data, exp));
    endtask

    task automatic check_group(input logic [4:0] base);
        for (int k = 0; k < (1 << m_vtype.vlmul); k++) begin
            for (int e = 0; e < VLEN / sew_bits(m_vtype.vsew); e++) begin
                check_elem(base + 5'(k), e);
            end
        end
    endtask

    function automatic logic [4:0] rand_group();
        int unsigned span;
        span = 1 << m_vtype.vlmul;
        return 5'(span * $urandom_range(0, NREGS / span - 1));
    endfunction

    function automatic vec_op_e pick_op(input int i);
        case (i)
            0:       return VAND;
            1:       return VOR;
            2:       return VXOR;
            3:       return VADD;
            default: return VSUB;
        endcase
    endfunction

    // Fresh sources and destination before one op under a random vl
    task automatic random_round(input vec_op_e op, input op_cat_e cat, input vew_e sew,
                                input vlmul_e lmul, input logic short_vl);
        vec_cmd_t    c;
        logic [31:0] vlmax;
        set_cfg(sew, lmul, 32'd64);
        vlmax = m_vl;
        c       = '0;
        c.op    = op;
        c.cat   = cat;
        c.vd    = rand_group();
        c.vs1   = rand_group();
        c.vs2   = rand_group();
        c.imm5  = 5'($urandom);
        c.scalar1 = $urandom;
        load_group(c.vs1, $urandom);
        load_group(c.vs2, $urandom);
        load_group(c.vd, $urandom);
        if (short_vl) begin
            set_cfg(sew, lmul, $urandom_range(1, vlmax - 1));
        end else begin
            set_cfg(sew, lmul, $urandom_range(1, vlmax));
        end
        run_op(c);
        check_group(c.vd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        vec_cmd_t c;
        void'($urandom(68));
        req     = 1'b0;
        cmd     = '0;
        reset   = 1'b1;
        m_regs  = '{default: '0};
        m_vtype = '0;
        m_vl    = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (ack === 1'b0 && rsp.wr_en === 1'b0)
            else abort_run($sformatf("ERR %0t: ack or wr_en high after reset", $time));

        // Configuration with zero rd and rs1 and reserved sew
        repeat (24) begin
            c = '0;
            case ($urandom_range(0, 2))
                0:       c.op = VSETVLI;
                1:       c.op = VSETVL;
                default: c.op = VSETIVLI;
            endcase
            c.vd  = ($urandom_range(0, 2) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
            c.vs1 = ($urandom_range(0, 2) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
            c.imm5              = 5'($urandom);
            c.scalar1           = $urandom_range(0, 80);
            c.vtype_imm.vsew    = vew_e'(3'($urandom_range(0, 3)));
            c.vtype_imm.vlmul   = vlmul_e'(3'($urandom_range(0, 3)));
            c.scalar2           = {26'b0, 3'($urandom_range(0, 3)), 3'($urandom_range(0, 3))};
            do_vset(c);
        end

        // Directed vlmax, kept vl and reserved sew cases
        c                 = '0;
        c.op              = VSETVLI;
        c.vd              = 5'd3;
        c.vtype_imm.vsew  = EW16;
        c.vtype_imm.vlmul = LMUL_2;
        do_vset(c);
        c.vd              = 5'd0;
        c.vtype_imm.vsew  = EW32;
        do_vset(c);
        c.op              = VSETVL;
        c.scalar2         = {26'b0, 3'd3, 3'd0};
        do_vset(c);

        // Fill a group at each sew and read back every element
        for (int s = 0; s < 3; s++) begin
            set_cfg(vew_e'(3'(s)), vlmul_e'(3'($urandom_range(0, 3))), 32'd64);
            c.vd = rand_group();
            load_group(c.vd, $urandom);
            check_group(c.vd);
        end

        // Write aimed at v0 is dropped
        set_cfg(EW32, LMUL_1, 32'd2);
        load_group(5'd0, $urandom);
        check_group(5'd0);

        // Every op in every operand form twice
        for (int i = 0; i < 30; i++) begin
            random_round(pick_op(i % 5), op_cat_e'(2'((i / 5) % 3)),
                         vew_e'(3'($urandom_range(0, 2))),
                         vlmul_e'(3'($urandom_range(0, 3))), 1'b0);
        end

        // Tails under LMUL 2, 4 and 8
        for (int l = 1; l < 4; l++) begin
            random_round(pick_op($urandom_range(0, 4)), op_cat_e'(2'($urandom_range(0, 2))),
                         vew_e'(3'($urandom_range(0, 2))), vlmul_e'(3'(l)), 1'b1);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== vector_unit_top.sv ====
`timescale 1ns/1ps

`include "vector_params.svh"

module vector_unit_top
    import vector_cmd_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  logic     req_i,
    input  vec_cmd_t cmd_i,

    output logic     ack_o,
    output vec_rsp_t rsp_o
);

    rf_access_t           rf;
    alu_ctrl_t            alu_ctrl;
    vew_e                 sew;
    logic [31:0]          alu_scalar;

    logic [`VEC_VLEN-1:0] vs1_data;
    logic [`VEC_VLEN-1:0] vs2_data;
    logic [`VEC_VLEN-1:0] first_op;
    logic [`VEC_VLEN-1:0] second_op;
    logic [`VEC_VLEN-1:0] result;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    vector_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req_i        (req_i),
        .cmd_i        (cmd_i),
        .alu_scalar_i (alu_scalar),
        .ack_o        (ack_o),
        .rsp_o        (rsp_o),
        .rf_o         (rf),
        .alu_ctrl_o   (alu_ctrl),
        .sew_o        (sew)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    vector_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .rf_i       (rf),
        .wdata_i    (result),
        .vs1_data_o (vs1_data),
        .vs2_data_o (vs2_data),
        .vd_data_o  ()
    );

    // Command fields are stable until ack, so they feed the operands directly
    vector_operand_sel u_operand_sel (
        .clk        (clk),
        .cat_i      (cmd_i.cat),
        .sew_i      (sew),
        .scalar_i   (cmd_i.scalar1),
        .imm5_i     (cmd_i.imm5),
        .vs1_data_i (vs1_data),
        .vs2_data_i (vs2_data),
        .first_o    (first_op),
        .second_o   (second_op)
    );

    vector_alu u_alu (
        .alu_ctrl_i (alu_ctrl),
        .first_i    (first_op),
        .second_i   (second_op),
        .result_o   (result),
        .scalar_o   (alu_scalar)
    );

endmodule

// ==== vector_ctrl.sv ====
`timescale 1ns/1ps

`include "vector_params.svh"

module vector_ctrl
    import vector_types_pkg::*;
    import vector_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        req_i,
    input  vec_cmd_t    cmd_i,
    input  logic [31:0] alu_scalar_i,

    output logic        ack_o,
    output vec_rsp_t    rsp_o,

    output rf_access_t  rf_o,
    output alu_ctrl_t   alu_ctrl_o,
    output vew_e        sew_o
);

    typedef enum logic [2:0] {
        IDLE,
        CONFIG,
        EXEC,
        DRAIN,
        DONE
    } state_e;

    state_e      state;
    vec_cmd_t    cmd_q;
    vtype_t      vtype_q;
    logic [31:0] vl_q;

    // Read side and write side group positions
    logic [2:0]  cnt;
    logic [2:0]  wcnt;
    logic        wvalid;

    logic [3:0]  group_size;
    logic        last_reg;
    logic        is_vset;

    vtype_t      vt_new;
    logic [31:0] vlmax;
    logic [31:0] avl;
    logic [31:0] vl_new;

    assign is_vset    = cmd_i.op inside {VSETVL, VSETVLI, VSETIVLI};
    assign group_size = 4'd1 << vtype_q.vlmul[1:0];
    assign last_reg   = ({1'b0, cnt} == group_size - 4'd1);

    //////////////////////////////////////////////////////////////////////
    // Configuration
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (cmd_q.op == VSETVL) begin
            vt_new = vtype_t'({cmd_q.scalar2[31], cmd_q.scalar2[7:0]});
        end else begin
            vt_new = cmd_q.vtype_imm;
        end

        vlmax = (32'(VLENB) >> vt_new.vsew) << vt_new.vlmul;

        if (cmd_q.op == VSETIVLI) begin
            avl = {27'b0, cmd_q.imm5};
        end else if (cmd_q.vd != '0 && cmd_q.vs1 == '0) begin
            avl = vlmax;
        end else begin
            avl = cmd_q.scalar1;
        end

        // rd and rs1 both zero keeps vl
        if (cmd_q.op != VSETIVLI && cmd_q.vd == '0 && cmd_q.vs1 == '0) begin
            vl_new = vl_q;
        end else begin
            vl_new = (avl < vlmax) ? avl : vlmax;
        end

        // Reserved encodings leave only vill set
        if (vt_new.vill || vt_new.vsew > EW32 || vt_new.vlmul[2]) begin
            vt_new      = '0;
            vt_new.vill = 1'b1;
            vl_new      = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == IDLE && req_i) begin
            cmd_q <= cmd_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            vtype_q <= '0;
            vl_q    <= '0;
            cnt     <= '0;
            wcnt    <= '0;
            wvalid  <= 1'b0;
            ack_o   <= 1'b0;
            rsp_o   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_i) begin
                        cnt    <= '0;
                        wvalid <= 1'b0;
                        state  <= is_vset ? CONFIG : EXEC;
                    end
                end
                CONFIG: begin
                    vtype_q     <= vt_new;
                    vl_q        <= vl_new;
                    rsp_o.data  <= vl_new;
                    rsp_o.wr_en <= 1'b1;
                    state       <= DONE;
                end
                EXEC: begin
                    // Extract only needs vs2 in the operand register
                    if (cmd_q.op == VEXT) begin
                        state <= DRAIN;
                    end else begin
                        wvalid <= 1'b1;
                        wcnt   <= cnt;
                        cnt    <= cnt + 3'd1;
                        if (last_reg) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    wvalid <= 1'b0;
                    if (cmd_q.op == VEXT) begin
                        rsp_o.data  <= alu_scalar_i;
                        rsp_o.wr_en <= 1'b1;
                    end
                    state <= DONE;
                end
                DONE: begin
                    if (req_i) begin
                        ack_o <= 1'b1;
                    end else if (ack_o) begin
                        ack_o <= 1'b0;
                        rsp_o <= '0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register file access
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        int unsigned epr;
        int unsigned elem;

        epr = VLENB >> vtype_q.vsew;

        rf_o.vs1_addr = cmd_q.vs1 + 5'(cnt);
        rf_o.vs2_addr = cmd_q.vs2 + 5'(cnt);
        rf_o.vd_addr  = cmd_q.vd + 5'(cnt);
        rf_o.wr_addr  = cmd_q.vd + 5'(wcnt);

        // Element index across the whole group decides the tail
        for (int b = 0; b < VLENB; b++) begin
            elem       = int'(wcnt) * epr + (b >> vtype_q.vsew);
            rf_o.be[b] = wvalid && !vtype_q.vill && (elem < vl_q);
        end
    end

    assign alu_ctrl_o = '{
        op:  cmd_q.op,
        sew: vtype_q.vsew,
        idx: cmd_q.scalar1[EIDX_W-1:0]
    };

    assign sew_o = vtype_q.vsew;

endmodule

// ==== vector_alu.sv ====
`timescale 1ns/1ps

`include "vector_params.svh"

module vector_alu
    import vector_types_pkg::*;
    import vector_cmd_pkg::*;
(
    input  alu_ctrl_t            alu_ctrl_i,

    input  logic [`VEC_VLEN-1:0] first_i,
    input  logic [`VEC_VLEN-1:0] second_i,

    output logic [`VEC_VLEN-1:0] result_o,
    output logic [31:0]          scalar_o
);

    int unsigned          ebytes;
    logic                 is_sub;
    logic [`VEC_VLEN-1:0] addend;
    logic [`VEC_VLEN-1:0] sum;
    logic [`VEC_VLEN-1:0] shifted;

    always_comb begin
        case (alu_ctrl_i.sew)
            EW8:     ebytes = 1;
            EW16:    ebytes = 2;
            default: ebytes = 4;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Byte sliced adder
    //////////////////////////////////////////////////////////////////////

    assign is_sub = (alu_ctrl_i.op == VSUB);
    assign addend = is_sub ? ~second_i : second_i;

    always_comb begin
        logic [8:0] byte_sum;
        logic       carry;

        carry = 1'b0;
        for (int b = 0; b < VLENB; b++) begin
            // Carry chain restarts at each element, with +1 for subtract
            if (b % ebytes == 0) begin
                carry = is_sub;
            end
            byte_sum = {1'b0, first_i[8*b +: 8]} + {1'b0, addend[8*b +: 8]} + {8'b0, carry};
            sum[8*b +: 8] = byte_sum[7:0];
            carry = byte_sum[8];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (alu_ctrl_i.op)
            VAND:       result_o = first_i & second_i;
            VOR:        result_o = first_i | second_i;
            VXOR:       result_o = first_i ^ second_i;
            VADD, VSUB: result_o = sum;
            default:    result_o = '0;
        endcase
    end

    // Element extract, zero extended
    assign shifted = first_i >> (int'(alu_ctrl_i.idx) * ebytes * 8);

    always_comb begin
        case (alu_ctrl_i.sew)
            EW8:     scalar_o = {24'b0, shifted[7:0]};
            EW16:    scalar_o = {16'b0, shifted[15:0]};
            default: scalar_o = shifted[31:0];
        endcase
    end

endmodule

// ==== vector_operand_sel.sv ====
`timescale 1ns/1ps

`include "vector_params.svh"

module vector_operand_sel
    import vector_types_pkg::*;
    import vector_cmd_pkg::*;
(
    input  logic                 clk,

    input  op_cat_e              cat_i,
    input  vew_e                 sew_i,
    input  logic [31:0]          scalar_i,
    input  logic [4:0]           imm5_i,

    input  logic [`VEC_VLEN-1:0] vs1_data_i,
    input  logic [`VEC_VLEN-1:0] vs2_data_i,

    output logic [`VEC_VLEN-1:0] first_o,
    output logic [`VEC_VLEN-1:0] second_o
);

    logic [`VEC_VLEN-1:0] scalar_rep;
    logic [`VEC_VLEN-1:0] imm_rep;

    //////////////////////////////////////////////////////////////////////
    // Replication at the current element width
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (sew_i)
            EW8:     scalar_rep = {(VLENB){scalar_i[7:0]}};
            EW16:    scalar_rep = {(VLENB/2){scalar_i[15:0]}};
            default: scalar_rep = {(VLENB/4){scalar_i}};
        endcase
    end

    // Immediate is sign extended to the element
    always_comb begin
        case (sew_i)
            EW8:     imm_rep = {(VLENB){{3{imm5_i[4]}}, imm5_i}};
            EW16:    imm_rep = {(VLENB/2){{11{imm5_i[4]}}, imm5_i}};
            default: imm_rep = {(VLENB/4){{27{imm5_i[4]}}, imm5_i}};
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Operand registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        first_o <= vs2_data_i;

        case (cat_i)
            OPIVX:   second_o <= scalar_rep;
            OPIVI:   second_o <= imm_rep;
            default: second_o <= vs1_data_i;
        endcase
    end

endmodule

// ==== vector_regfile.sv ====
`timescale 1ns/1ps

`include "vector_params.svh"

module vector_regfile
    import vector_cmd_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,

    input  rf_access_t           rf_i,
    input  logic [`VEC_VLEN-1:0] wdata_i,

    output logic [`VEC_VLEN-1:0] vs1_data_o,
    output logic [`VEC_VLEN-1:0] vs2_data_o,
    output logic [`VEC_VLEN-1:0] vd_data_o
);

    logic [`VEC_NREGS-1:0][`VEC_VLEN-1:0] regs;

    // Byte lane writes, v0 stays zero
    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else if (rf_i.wr_addr != '0) begin
            for (int b = 0; b < VLENB; b++) begin
                if (rf_i.be[b]) begin
                    regs[rf_i.wr_addr][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Asynchronous read ports
    assign vs1_data_o = regs[rf_i.vs1_addr];
    assign vs2_data_o = regs[rf_i.vs2_addr];
    assign vd_data_o  = regs[rf_i.vd_addr];

endmodule

// ==== vector_cmd_pkg.sv ====
`include "vector_params.svh"

package vector_cmd_pkg;

    import vector_types_pkg::*;
    export vector_types_pkg::*;

    localparam int VLENB  = `VEC_VLEN / 8;
    localparam int EIDX_W = $clog2(VLENB);

    //////////////////////////////////////////////////////////////////////
    // Host command and response
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        VSETVL,
        VSETVLI,
        VSETIVLI,
        VAND,
        VOR,
        VXOR,
        VADD,
        VSUB,
        VEXT
    } vec_op_e;

    typedef enum logic [1:0] {
        OPIVV,
        OPIVX,
        OPIVI
    } op_cat_e;

    // For vset commands vd is rd and vs1 is rs1
    typedef struct packed {
        vec_op_e     op;
        op_cat_e     cat;
        logic [4:0]  vd;
        logic [4:0]  vs1;
        logic [4:0]  vs2;
        logic [4:0]  imm5;
        vtype_t      vtype_imm;
        logic [31:0] scalar1;
        logic [31:0] scalar2;
    } vec_cmd_t;

    typedef struct packed {
        logic [31:0] data;
        logic        wr_en;
    } vec_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // Internal control
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [4:0]       vs1_addr;
        logic [4:0]       vs2_addr;
        logic [4:0]       vd_addr;
        logic [4:0]       wr_addr;
        logic [VLENB-1:0] be;
    } rf_access_t;

    typedef struct packed {
        vec_op_e           op;
        vew_e              sew;
        logic [EIDX_W-1:0] idx;
    } alu_ctrl_t;

endpackage

// ==== vector_types_pkg.sv ====
package vector_types_pkg;

    //////////////////////////////////////////////////////////////////////
    // Architectural vector state
    //////////////////////////////////////////////////////////////////////

    // Selected element width, EW64 is reserved here
    typedef enum logic [2:0] {
        EW8  = 3'b000,
        EW16 = 3'b001,
        EW32 = 3'b010,
        EW64 = 3'b011
    } vew_e;

    // Register group size
    typedef enum logic [2:0] {
        LMUL_1 = 3'b000,
        LMUL_2 = 3'b001,
        LMUL_4 = 3'b010,
        LMUL_8 = 3'b011
    } vlmul_e;

    // Same bit order as the low byte of the vtype CSR, vill on top
    typedef struct packed {
        logic   vill;
        logic   vma;
        logic   vta;
        vew_e   vsew;
        vlmul_e vlmul;
    } vtype_t;

endpackage

// ==== vector_params.svh ====
`ifndef VECTOR_PARAMS_SVH
`define VECTOR_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Vector unit sizing
//////////////////////////////////////////////////////////////////////

// Register width in bits, a multiple of 32
`define VEC_VLEN 64

// Architectural vector registers
`define VEC_NREGS 32

`endif
